// ==== logic/obj_defs.svh ====
/* Object engine sizes
   Table, sprite, ROM and scan limits shared by RTL and testbench */

`ifndef OBJ_DEFS_SVH
`define OBJ_DEFS_SVH

// Sprite entries walked on every line
`define OBJ_COUNT 16

// Sprites are square, width equals height
`define OBJ_SIZE 16

// CPU side address of one object table
`define OBJ_TABLE_AW 10

// Graphics ROM word address
`define OBJ_ROM_AW 14

// First byte of the row scroll area
`define OBJ_SCROLL_BASE 64

`endif

// ==== logic/obj_pkg.sv ====
/* Object engine types
   Table byte views, draw request and graphics ROM request */

`default_nettype none

`include "obj_defs.svh"

package obj_pkg;

    // One table byte, seen as sprite attribute or as row scroll low byte
    typedef union packed {
        struct packed {
            logic       vflip;
            logic       hflip;
            logic       code8;
            logic       spare;
            logic [3:0] pal;
        } attr;
        struct packed {
            logic [6:0] hpos_lo;
            logic       spare;
        } scroll;
    } obj_table_word_u;

    // Everything the drawer needs for one sprite line
    typedef struct packed {
        logic [8:0] code;
        logic [7:0] xpos;
        logic [3:0] pal;
        logic       hflip;
        logic       vflip;
        logic [3:0] ysub;
    } obj_draw_req_t;

    // cs stays up until the ROM answers with ok
    typedef struct packed {
        logic [`OBJ_ROM_AW-1:0] addr;
        logic                   cs;
    } obj_rom_req_t;

endpackage

`default_nettype wire

// ==== logic/obj_table_ram.sv ====
/* Object table RAM
   Two 1 KB banks, one owned by the CPU and the other read by the scanner */

`timescale 1ns/1ns
`default_nettype none

`include "obj_defs.svh"

module obj_table_ram (
    input  wire                     clk,
    input  wire [`OBJ_TABLE_AW-1:0] cpu_addr,
    input  wire [7:0]               cpu_dout,
    input  wire                     cpu_cs,
    input  wire                     cpu_rnw,
    input  wire                     obj_frame,
    output logic [7:0]              obj_dout,
    input  wire [6:0]               scan_addr,
    output logic [7:0]              scan_dout
);

    localparam int DEPTH = 1 << `OBJ_TABLE_AW;

    // Bank 1 belongs to the CPU while obj_frame is high
    logic [7:0] tab [2][DEPTH];

    logic                     cpu_we;
    logic [`OBJ_TABLE_AW-1:0] scan_full;

    assign cpu_we = cpu_cs && !cpu_rnw;

    // Scanner only reaches the lowest 128 bytes
    assign scan_full = {{(`OBJ_TABLE_AW - 7){1'b0}}, scan_addr};

    always_ff @(posedge clk) begin
        if (cpu_we) begin
            tab[obj_frame][cpu_addr] <= cpu_dout;
        end
        // Both read ports are registered
        obj_dout  <= tab[obj_frame][cpu_addr];
        scan_dout <= tab[~obj_frame][scan_full];
    end

endmodule

`default_nettype wire

// ==== logic/obj_scan.sv ====
/* Object table scanner
   Fetches row scroll, then tests each entry against the next line */

`timescale 1ns/1ns
`default_nettype none

`include "obj_defs.svh"

module obj_scan
    import obj_pkg::*;
(
    input  wire           clk,
    input  wire           rst,
    input  wire           hinit,
    input  wire [8:0]     vdump,
    output logic [6:0]    scan_addr,
    input  wire [7:0]     scan_dout,
    output logic [7:0]    hpos,
    output logic          scr_we,
    output logic          draw,
    output obj_draw_req_t req,
    input  wire           busy
);

    localparam int IW = $clog2(`OBJ_COUNT);
    localparam logic [6:0] SCROLL_BASE = 7'(`OBJ_SCROLL_BASE);

    typedef enum logic [2:0] {
        SC_IDLE,
        SC_SCR0,
        SC_SCR1,
        SC_SCR2,
        SC_ATTR,
        SC_Y,
        SC_CODE,
        SC_X
    } scan_state_e;

    scan_state_e     st;
    logic [IW-1:0]   idx;
    logic [7:0]      line_v;
    logic [7:0]      zone_d;
    logic [6:0]      scroll_row;
    logic [6:0]      scroll_lo;
    logic            inzone;
    logic            stall;
    obj_table_word_u tw;

    assign tw = scan_dout;

    // Two scroll bytes per group of 8 lines
    assign scroll_row = SCROLL_BASE + {1'b0, line_v[7:3], 1'b0};

    // Distance from sprite top to the line being prepared
    assign zone_d = line_v + 8'd1 - scan_dout;

    // Only a sprite that will be drawn has to wait for the drawer
    assign stall = inzone && busy;

    // Address is presented one state ahead of the byte it returns
    always_comb begin
        case (st)
            SC_SCR0: scan_addr = scroll_row;
            SC_SCR1: scan_addr = scroll_row | 7'd1;
            SC_ATTR: scan_addr = 7'({idx, 2'd1});
            SC_Y:    scan_addr = 7'({idx, 2'd2});
            SC_CODE: scan_addr = 7'({idx, 2'd3});
            // Hold x while waiting, else start on the next entry
            SC_X:    scan_addr = stall ? 7'({idx, 2'd3}) : 7'({idx - 1'b1, 2'd0});
            default: scan_addr = 7'({idx, 2'd0});
        endcase
    end

    // Sequencing; hinit restarts from any state
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            st     <= SC_IDLE;
            idx    <= '0;
            draw   <= 1'b0;
            scr_we <= 1'b0;
        end else begin
            draw   <= 1'b0;
            scr_we <= 1'b0;
            if (hinit) begin
                st  <= SC_SCR0;
                idx <= IW'(`OBJ_COUNT - 1);
            end else begin
                case (st)
                    SC_SCR0: st <= SC_SCR1;
                    SC_SCR1: st <= SC_SCR2;
                    SC_SCR2: begin
                        // Third edge after the one that samples hinit
                        scr_we <= 1'b1;
                        st     <= SC_ATTR;
                    end
                    SC_ATTR: st <= SC_Y;
                    SC_Y:    st <= SC_CODE;
                    SC_CODE: st <= SC_X;
                    SC_X: begin
                        if (!stall) begin
                            draw <= inzone;
                            idx  <= idx - 1'b1;
                            st   <= (idx == '0) ? SC_IDLE : SC_ATTR;
                        end
                    end
                    default: st <= SC_IDLE;
                endcase
            end
        end
    end

    // Captured table fields
    always_ff @(posedge clk) begin
        if (hinit) begin
            line_v <= vdump[7:0];
        end
        case (st)
            SC_SCR1: scroll_lo <= tw.scroll.hpos_lo;
            SC_SCR2: hpos <= {scan_dout[0], scroll_lo};
            SC_ATTR: begin
                req.vflip   <= tw.attr.vflip;
                req.hflip   <= tw.attr.hflip;
                req.pal     <= tw.attr.pal;
                req.code[8] <= tw.attr.code8;
            end
            SC_Y: begin
                inzone <= zone_d < 8'(`OBJ_SIZE);
                // 15-d under vflip
                req.ysub <= req.vflip ? ~zone_d[3:0] : zone_d[3:0];
            end
            SC_CODE: req.code[7:0] <= scan_dout;
            SC_X: begin
                if (!stall) begin
                    req.xpos <= scan_dout;
                end
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// ==== logic/obj_draw.sv ====
/* Sprite line drawer
   Two ROM words per sprite line, palette lookup, line buffer writes */

`timescale 1ns/1ns
`default_nettype none

`include "obj_defs.svh"

module obj_draw
    import obj_pkg::*;
(
    input  wire           clk,
    input  wire           rst,
    input  wire           draw,
    input  obj_draw_req_t req,
    output logic          busy,
    output obj_rom_req_t  rom,
    input  wire [31:0]    rom_data,
    input  wire           rom_ok,
    input  wire [7:0]     prog_addr,
    input  wire [3:0]     prog_data,
    input  wire           prog_en,
    output logic [7:0]    lb_addr,
    output logic [3:0]    lb_data,
    output logic          lb_we
);

    typedef enum logic [1:0] {
        DR_IDLE,
        DR_FETCH,
        DR_SHIFT
    } draw_state_e;

    draw_state_e            st;
    obj_draw_req_t          cur;
    logic [`OBJ_ROM_AW-1:0] rom_addr;
    logic                   rom_cs;
    logic                   half;
    logic [2:0]             nib_cnt;
    logic [31:0]            pix_sr;
    logic [3:0]             nib;
    logic [3:0]             col;
    logic                   start;
    logic                   take;
    logic                   last_nib;

    // Palette PROM with 16 colors for each of 16 palettes
    logic [3:0] prom [256];

    assign rom = '{addr: rom_addr, cs: rom_cs};

    // Lowest nibble is the leftmost pixel of the word
    assign nib      = pix_sr[3:0];
    assign col      = {half, nib_cnt};
    assign start    = (st == DR_IDLE) && draw;
    assign take     = (st == DR_FETCH) && rom_ok;
    assign last_nib = (st == DR_SHIFT) && (nib_cnt == 3'd7);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            st      <= DR_IDLE;
            busy    <= 1'b0;
            rom_cs  <= 1'b0;
            half    <= 1'b0;
            nib_cnt <= '0;
            lb_we   <= 1'b0;
        end else begin
            lb_we <= 1'b0;
            case (st)
                DR_IDLE: begin
                    if (draw) begin
                        busy   <= 1'b1;
                        rom_cs <= 1'b1;
                        half   <= 1'b0;
                        st     <= DR_FETCH;
                    end
                end
                DR_FETCH: begin
                    // Wait out the ROM latency
                    if (rom_ok) begin
                        rom_cs  <= 1'b0;
                        nib_cnt <= '0;
                        st      <= DR_SHIFT;
                    end
                end
                DR_SHIFT: begin
                    // Color 0 is transparent
                    lb_we   <= nib != 4'd0;
                    nib_cnt <= nib_cnt + 1'b1;
                    if (last_nib) begin
                        if (half) begin
                            busy <= 1'b0;
                            st   <= DR_IDLE;
                        end else begin
                            half   <= 1'b1;
                            rom_cs <= 1'b1;
                            st     <= DR_FETCH;
                        end
                    end
                end
                default: st <= DR_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            cur      <= req;
            rom_addr <= {req.code, req.ysub, 1'b0};
        end
        // Right half once the left one is out
        if (last_nib && !half) begin
            rom_addr <= {cur.code, cur.ysub, 1'b1};
        end
        if (take) begin
            pix_sr <= rom_data;
        end else if (st == DR_SHIFT) begin
            pix_sr <= pix_sr >> 4;
        end
        if (st == DR_SHIFT) begin
            // hflip mirrors column i to 15-i
            lb_addr <= cur.xpos + {4'd0, col ^ {4{cur.hflip}}};
            lb_data <= prom[{cur.pal, nib}];
        end
    end

    always_ff @(posedge clk) begin
        if (prog_en) begin
            prom[prog_addr] <= prog_data;
        end
    end

endmodule

`default_nettype wire

// ==== logic/obj_linebuf.sv ====
/* Sprite line buffer
   Ping-pong 256x4 banks with one drawn while the other is shown and cleared */

`timescale 1ns/1ns
`default_nettype none

module obj_linebuf (
    input  wire        clk,
    input  wire        rst,
    input  wire        hinit,
    input  wire        pxl_cen,
    input  wire [8:0]  hdump,
    input  wire [7:0]  wr_addr,
    input  wire [3:0]  wr_data,
    input  wire        we,
    output logic [3:0] pxl
);

    logic [3:0] mem [2][256];
    logic       draw_bank;
    logic       show_bank;
    logic [7:0] rd_addr;

    // Columns wrap at 256 since hdump bit 8 is ignored
    assign rd_addr = hdump[7:0];

    // On the hinit clock the bank just drawn is already the one on show
    assign show_bank = hinit ? draw_bank : ~draw_bank;

    // Drawn bank becomes the shown bank at the next line start
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            draw_bank <= 1'b0;
        end else if (hinit) begin
            draw_bank <= ~draw_bank;
        end
    end

    always_ff @(posedge clk) begin
        if (we) begin
            mem[draw_bank][wr_addr] <= wr_data;
        end
        if (pxl_cen) begin
            pxl <= mem[show_bank][rd_addr];
            // Erase behind the beam so the bank starts empty when drawn again
            mem[show_bank][rd_addr] <= 4'd0;
        end
    end

endmodule

`default_nettype wire

// ==== logic/obj_video.sv ====
/* Object engine top
   Tables, scanner, drawer and line buffer of the sprite subsystem */

`timescale 1ns/1ns
`default_nettype none

`include "obj_defs.svh"

module obj_video
    import obj_pkg::*;
(
    input  wire                     clk,
    input  wire                     rst,
    input  wire [`OBJ_TABLE_AW-1:0] cpu_addr,
    input  wire [7:0]               cpu_dout,
    input  wire                     cpu_cs,
    input  wire                     cpu_rnw,
    input  wire                     obj_frame,
    output logic [7:0]              obj_dout,
    input  wire                     hinit,
    input  wire [8:0]               vdump,
    input  wire [8:0]               hdump,
    input  wire                     pxl_cen,
    output logic [7:0]              hpos,
    output logic                    scr_we,
    input  wire [7:0]               prog_addr,
    input  wire [3:0]               prog_data,
    input  wire                     prog_en,
    output obj_rom_req_t            rom,
    input  wire [31:0]              rom_data,
    input  wire                     rom_ok,
    output logic [3:0]              pxl
);

    logic [6:0]    scan_addr;
    logic [7:0]    scan_dout;
    logic          draw;
    logic          busy;
    obj_draw_req_t req;
    logic [7:0]    lb_addr;
    logic [3:0]    lb_data;
    logic          lb_we;

    obj_table_ram u_table (
        .clk       (clk),
        .cpu_addr  (cpu_addr),
        .cpu_dout  (cpu_dout),
        .cpu_cs    (cpu_cs),
        .cpu_rnw   (cpu_rnw),
        .obj_frame (obj_frame),
        .obj_dout  (obj_dout),
        .scan_addr (scan_addr),
        .scan_dout (scan_dout)
    );

    obj_scan u_scan (
        .clk       (clk),
        .rst       (rst),
        .hinit     (hinit),
        .vdump     (vdump),
        .scan_addr (scan_addr),
        .scan_dout (scan_dout),
        .hpos      (hpos),
        .scr_we    (scr_we),
        .draw      (draw),
        .req       (req),
        .busy      (busy)
    );

    obj_draw u_draw (
        .clk       (clk),
        .rst       (rst),
        .draw      (draw),
        .req       (req),
        .busy      (busy),
        .rom       (rom),
        .rom_data  (rom_data),
        .rom_ok    (rom_ok),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .prog_en   (prog_en),
        .lb_addr   (lb_addr),
        .lb_data   (lb_data),
        .lb_we     (lb_we)
    );

    obj_linebuf u_linebuf (
        .clk     (clk),
        .rst     (rst),
        .hinit   (hinit),
        .pxl_cen (pxl_cen),
        .hdump   (hdump),
        .wr_addr (lb_addr),
        .wr_data (lb_data),
        .we      (lb_we),
        .pxl     (pxl)
    );

endmodule

`default_nettype wire

// ==== tb/tb_obj_video.sv ====
/* Object engine testbench
   Random tables, palettes and ROM latency checked against a line model */

`timescale 1ns/1ns
`default_nettype none

`include "obj_defs.svh"

module tb_obj_video
    import obj_pkg::*;
();

    localparam int LINE_CLKS  = 768;
    localparam int NUM_LINES  = 17;
    localparam int SETUP_CLKS = 5000;

    logic         clk = 1'b0;
    logic         rst;
    logic [9:0]   cpu_addr;
    logic [7:0]   cpu_dout;
    logic         cpu_cs;
    logic         cpu_rnw;
    logic         obj_frame;
    logic [7:0]   obj_dout;
    logic         hinit;
    logic [8:0]   vdump;
    logic [8:0]   hdump;
    logic         pxl_cen;
    logic [7:0]   hpos;
    logic         scr_we;
    logic [7:0]   prog_addr;
    logic [3:0]   prog_data;
    logic         prog_en;
    obj_rom_req_t rom;
    logic [31:0]  rom_data;
    logic         rom_ok;
    logic [3:0]   pxl;

    // Model state of both tables, palette PROM, line being drawn and line shown
    logic [7:0] tbl [2][1024];
    logic [3:0] prom_m [256];
    logic [3:0] pend_line [256];
    logic [3:0] disp_line [256];
    logic [7:0] exp_hpos;
    int         lines_run;
    int         err_total;
    int         err_test;
    int         tests_run;
    int         tests_failed;

    obj_video u_dut (
        .clk (clk), .rst (rst),
        .cpu_addr (cpu_addr), .cpu_dout (cpu_dout), .cpu_cs (cpu_cs),
        .cpu_rnw (cpu_rnw), .obj_frame (obj_frame), .obj_dout (obj_dout),
        .hinit (hinit), .vdump (vdump), .hdump (hdump), .pxl_cen (pxl_cen),
        .hpos (hpos), .scr_we (scr_we),
        .prog_addr (prog_addr), .prog_data (prog_data), .prog_en (prog_en),
        .rom (rom), .rom_data (rom_data), .rom_ok (rom_ok), .pxl (pxl)
    );

    always #4 clk = ~clk;

    // Graphics ROM contents with one nibble per word forced transparent
    function automatic logic [31:0] rom_hash(input logic [`OBJ_ROM_AW-1:0] a);
        logic [31:0] h;
        h = {18'd0, a} * 32'h9e3779b1;
        h = h ^ (h >> 13) ^ {a, 18'h2a5c3};
        h[{a[2:0], 2'b00} +: 4] = 4'd0;
        return h;
    endfunction

    // ROM with 1 to 6 clocks of latency and ok high for one clock
    initial begin
        int dly;
        rom_data = '0;
        rom_ok   = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            if (rom.cs && !rom_ok) begin
                dly = $urandom_range(1, 6);
                repeat (dly - 1) @(posedge clk);
                #1;
                rom_data = rom_hash(rom.addr);
                rom_ok   = 1'b1;
                @(posedge clk);
                #1;
                rom_ok = 1'b0;
                // The drawer drops cs on the clock that takes the data
                if (rom.cs !== 1'b0) begin
                    count_error();
                    $display("ROM cs still high on the clock after rom_ok");
                end
            end
        end
    end

    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    task automatic count_error();
        err_test++;
        err_total++;
    endtask

    task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
        if (act !== exp) begin
            count_error();
            $display("MISMATCH %s expected %02h actual %02h", name, exp, act);
        end
    endtask

    task automatic check_pxl(input string name, input logic [3:0] exp, input logic [3:0] act);
        if (act !== exp) begin
            count_error();
            $display("MISMATCH %s expected %01h actual %01h", name, exp, act);
        end
    endtask

    task automatic check_hpos(input string name, input logic [7:0] exp, input logic [7:0] act);
        if (act !== exp) begin
            count_error();
            $display("MISMATCH %s expected hpos %02h actual %02h", name, exp, act);
        end
    endtask

    task automatic write_byte(input logic f, input int addr, input logic [7:0] data);
        obj_frame = f;
        cpu_addr  = 10'(addr);
        cpu_dout  = data;
        cpu_cs    = 1'b1;
        cpu_rnw   = 1'b0;
        tick();
        cpu_cs  = 1'b0;
        cpu_rnw = 1'b1;
        tbl[f][addr] = data;
    endtask

    task automatic load_prom();
        for (int a = 0; a < 256; a++) begin
            prog_addr = 8'(a);
            prog_data = 4'($urandom);
            prog_en   = 1'b1;
            tick();
            prom_m[a] = prog_data;
        end
        prog_en = 1'b0;
    endtask

    // Random entries mostly within reach of line v+1 plus random row scroll
    task automatic fill_bank(input logic f, input logic [7:0] v, input bit flips);
        logic [7:0] attr;
        for (int n = 0; n < `OBJ_COUNT; n++) begin
            attr = 8'($urandom);
            if (!flips) attr[7:6] = 2'b00;
            write_byte(f, 4 * n, attr);
            write_byte(f, 4 * n + 1, v + 8'd1 - 8'($urandom_range(0, 19)));
            write_byte(f, 4 * n + 2, 8'($urandom));
            write_byte(f, 4 * n + 3, 8'($urandom));
        end
        for (int a = `OBJ_SCROLL_BASE; a < 128; a++) begin
            write_byte(f, a, 8'($urandom));
        end
    endtask

    // Sprites crowded on a few columns with y right at the zone edges
    task automatic fill_edges(input logic f, input logic [7:0] v);
        logic [7:0] dsel;
        for (int n = 0; n < `OBJ_COUNT; n++) begin
            case ($urandom_range(0, 3))
                0: dsel = 8'd0;
                1: dsel = 8'd15;
                2: dsel = 8'd16;
                default: dsel = 8'd255;
            endcase
            write_byte(f, 4 * n, 8'($urandom));
            write_byte(f, 4 * n + 1, v + 8'd1 - dsel);
            write_byte(f, 4 * n + 2, 8'($urandom));
            write_byte(f, 4 * n + 3, 8'd120 + 8'($urandom_range(0, 7)));
        end
    endtask

    function automatic logic [7:0] scroll_of(input logic [7:0] v);
        obj_table_word_u lo;
        int              sb;
        int              a;
        sb = obj_frame ? 0 : 1;
        a  = `OBJ_SCROLL_BASE + 2 * int'(v[7:3]);
        lo = tbl[sb][a];
        return {tbl[sb][a + 1][0], lo.scroll.hpos_lo};
    endfunction

    // Line v+1 from the scanner's bank with entry 0 drawn last so it lands on top
    task automatic render_line(input logic [7:0] v);
        obj_table_word_u at;
        logic [7:0]      yb;
        logic [7:0]      xb;
        logic [7:0]      d;
        logic [7:0]      col;
        logic [8:0]      code;
        logic [3:0]      ys;
        logic [3:0]      nib;
        logic [31:0]     w;
        int              sb;
        sb = obj_frame ? 0 : 1;
        for (int i = 0; i < 256; i++) pend_line[i] = 4'd0;
        for (int n = `OBJ_COUNT - 1; n >= 0; n--) begin
            at   = tbl[sb][4 * n];
            yb   = tbl[sb][4 * n + 1];
            code = {at.attr.code8, tbl[sb][4 * n + 2]};
            xb   = tbl[sb][4 * n + 3];
            d    = v + 8'd1 - yb;
            if (d < 8'(`OBJ_SIZE)) begin
                ys = at.attr.vflip ? 4'd15 - d[3:0] : d[3:0];
                for (int i = 0; i < `OBJ_SIZE; i++) begin
                    w   = rom_hash({code, ys, i[3]});
                    nib = w[4 * (i % 8) +: 4];
                    col = at.attr.hflip ? xb + 8'd15 - 8'(i) : xb + 8'(i);
                    if (nib != 4'd0) pend_line[col] = prom_m[{at.attr.pal, nib}];
                end
            end
        end
    endtask

    // One video line with hdump 0..383, pxl_cen on even clocks and hinit at the start
    task automatic run_line(input string name, input logic [8:0] v);
        int hd;
        for (int cnt = 0; cnt < LINE_CLKS; cnt++) begin
            hd      = cnt / 2;
            hinit   = (cnt == 0);
            hdump   = 9'(hd);
            pxl_cen = (cnt % 2 == 0);
            if (cnt == 0) begin
                vdump = v;
                for (int i = 0; i < 256; i++) disp_line[i] = pend_line[i];
                render_line(v[7:0]);
                exp_hpos = scroll_of(v[7:0]);
            end
            tick();
            if (scr_we !== (cnt == 3)) begin
                count_error();
                $display("%s: scr_we is not one pulse 4 clocks after hinit (clock %0d)",
                         name, cnt);
            end
            if (cnt == 3) check_hpos(name, exp_hpos, hpos);
            // Columns past 255 read back locations already cleared
            if (pxl_cen && lines_run >= 2) begin
                check_pxl(name, (hd < 256) ? disp_line[8'(hd)] : 4'd0, pxl);
            end
        end
        hinit   = 1'b0;
        pxl_cen = 1'b0;
        lines_run++;
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (err_test != 0) tests_failed++;
        $display("test %-12s %s (%0d errors)", name, (err_test == 0) ? "ok" : "failed", err_test);
        err_test = 0;
    endtask

    // Watchdog sized from the line count plus table and PROM loading
    initial begin
        #((NUM_LINES * LINE_CLKS + SETUP_CLKS) * 8);
        $display("Timeout: run did not finish within %0d clocks",
                 NUM_LINES * LINE_CLKS + SETUP_CLKS);
        $display("Result: FAILED");
        $finish;
    end

    initial begin
        logic [10:0] rd_q [$];
        logic        f;
        logic [8:0]  v;
        void'($urandom(32'h8f8e2dfa));
        rst = 1'b1;
        cpu_addr = '0;
        cpu_dout = '0;
        cpu_cs = 1'b0;
        cpu_rnw = 1'b1;
        obj_frame = 1'b0;
        hinit = 1'b0;
        vdump = '0;
        hdump = '0;
        pxl_cen = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        prog_en = 1'b0;
        lines_run = 0;
        err_total = 0;
        err_test = 0;
        tests_run = 0;
        tests_failed = 0;
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;
        load_prom();

        // CPU writes to both banks read back one clock after the address
        for (int k = 0; k < 64; k++) begin
            f = 1'($urandom);
            rd_q.push_back({f, 10'($urandom)});
            write_byte(f, int'(rd_q[k][9:0]), 8'($urandom));
            // Same address in the other bank so a bank mix-up shows
            write_byte(!f, int'(rd_q[k][9:0]), 8'($urandom));
        end
        foreach (rd_q[k]) begin
            obj_frame = rd_q[k][10];
            cpu_addr  = rd_q[k][9:0];
            cpu_rnw   = 1'b1;
            cpu_cs    = 1'b1;
            tick();
            check_byte("cpu_readback", tbl[rd_q[k][10]][rd_q[k][9:0]], obj_dout);
        end
        cpu_cs = 1'b0;
        end_test("cpu_readback");

        // Bank 0 becomes the scanner bank
        fill_bank(1'b0, 8'd40, 1'b0);
        obj_frame = 1'b1;
        for (int k = 0; k < 4; k++) run_line("row_scroll", 9'($urandom_range(0, 255)));
        end_test("row_scroll");

        v = 9'($urandom_range(0, 253));
        fill_bank(1'b1, v[7:0], 1'b0);
        obj_frame = 1'b0;
        for (int k = 0; k < 3; k++) run_line("plain", v + 9'(k));
        end_test("plain");

        // PROM reloaded before every line
        v = 9'($urandom_range(0, 253));
        fill_bank(1'b0, v[7:0], 1'b1);
        obj_frame = 1'b1;
        for (int k = 0; k < 3; k++) begin
            load_prom();
            run_line("flip_palette", v + 9'(k));
        end
        end_test("flip_palette");

        // Line 255 prepares line 0 so sprite y wraps around
        fill_edges(1'b1, 8'd255);
        obj_frame = 1'b0;
        run_line("priority", 9'd255);
        run_line("priority", 9'd255);
        run_line("priority", 9'd0);
        end_test("priority");

        v = 9'($urandom_range(0, 255));
        fill_bank(1'b0, v[7:0], 1'b1);
        fill_bank(1'b1, v[7:0], 1'b1);
        for (int k = 0; k < 4; k++) begin
            obj_frame = 1'(k);
            run_line("bank_swap", v);
        end
        end_test("bank_swap");

        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, err_total);
        if (err_total == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== obj_video.f ====
+incdir+logic
logic/obj_pkg.sv
logic/obj_table_ram.sv
logic/obj_scan.sv
logic/obj_draw.sv
logic/obj_linebuf.sv
logic/obj_video.sv
tb/tb_obj_video.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the object engine testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f obj_video.f --top-module tb_obj_video \
    --Mdir obj_dir -o vsim > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
    cat build.log
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/vsim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

# The testbench verdict decides the script status
if grep -q "^Result: PASSED$" sim.log; then
    exit 0
fi
exit 1
